// File: src.f
hdl/board_pkg.sv
hdl/spi_xfer_if.sv
hdl/avr_spi_slave.sv
hdl/avr_cmd_regs.sv
hdl/covox_pwm.sv
hdl/board_test_top.sv
test/board_test_assertions.sv
test/tb_board_test.sv

// File: run.sh
#!/bin/sh
# build and run the board test simulation with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_board_test \
    -Mdir obj_dir -o tb_board_test \
    -f src.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_board_test > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
    echo "simulation reported failures"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

echo "simulation finished cleanly"
exit 0

// File: test/tb_board_test.sv
`timescale 1ns/1ps
`default_nettype none

module tb_board_test;

    localparam int TIMEOUT = 4096;

    logic        fclk;
    logic        rst_n;
    logic        spick;
    logic        spics_n;
    logic        spido;
    logic        sddi;
    logic        spidi;
    logic        sdcs_n;
    logic        sddo;
    logic        sdclk;
    logic        beep;
    logic        clkz_out;
    logic        spiint_n;
    logic [13:0] a;
    logic        rompg0_n;
    logic        dos_n;
    logic        rompg2;
    logic        rompg3;
    logic        rompg4;
    logic        csrom;
    logic        romoe_n;
    logic        romwe_n;
    wire  [7:0]  d;

    // flash chip contents and the expected contents
    logic [7:0]  flash_mem [0:511];
    logic [7:0]  exp_mem [0:511];

    // reference model state
    logic [18:0] m_addr;
    logic        m_cs;
    logic        m_oe;
    logic        m_we;
    logic        m_postinc;
    logic [7:0]  m_wdata;
    logic [7:0]  m_covox;
    logic        m_int_en;

    board_test_top #(
        .OSC_W (10)
    ) uut (
        .fclk     (fclk),
        .rst_n    (rst_n),
        .spick    (spick),
        .spics_n  (spics_n),
        .spido    (spido),
        .sddi     (sddi),
        .spidi    (spidi),
        .sdcs_n   (sdcs_n),
        .sddo     (sddo),
        .sdclk    (sdclk),
        .beep     (beep),
        .clkz_out (clkz_out),
        .spiint_n (spiint_n),
        .a        (a),
        .rompg0_n (rompg0_n),
        .dos_n    (dos_n),
        .rompg2   (rompg2),
        .rompg3   (rompg3),
        .rompg4   (rompg4),
        .csrom    (csrom),
        .romoe_n  (romoe_n),
        .romwe_n  (romwe_n),
        .d        (d)
    );

    // ------------------------------------------------------------
    // flash chip model
    // ------------------------------------------------------------
    assign d = !romoe_n ? flash_mem[a[8:0]] : 8'bzzzz_zzzz;

    // write strobe ends on the rising edge
    always @(posedge romwe_n)
    begin
        if (rst_n)
            flash_mem[a[8:0]] <= d;
    end

    initial
    begin
        fclk = 1'b0;
        forever #2 fclk = ~fclk;
    end

    function automatic logic [7:0] fill_byte(input int idx);
        return 8'(idx * 29) ^ 8'(idx >> 5);
    endfunction

    // ------------------------------------------------------------
    // checking
    // ------------------------------------------------------------
    task fail_run(input string why);
        begin
            $display("%s", why);
            $display("Test failures found");
            $fatal(1, "simulation stopped at first error");
        end
    endtask

    task check(input string name, input logic [31:0] got, input logic [31:0] exp);
        begin
            if (got !== exp)
                fail_run($sformatf("ERR %0t %s got %0h expected %0h", $time, name, got, exp));
        end
    endtask

    task check_pins;
        begin
            check("a", a, m_addr[13:0]);
            check("rompg0_n", rompg0_n, !m_addr[14]);
            check("dos_n", dos_n, m_addr[15]);
            check("rompg2", rompg2, m_addr[16]);
            check("rompg3", rompg3, m_addr[17]);
            check("rompg4", rompg4, m_addr[18]);
            check("csrom", csrom, m_cs);
            check("romoe_n", romoe_n, !m_oe);
            check("romwe_n", romwe_n, !m_we);
        end
    endtask

    // ------------------------------------------------------------
    // avr side of the spi link
    // ------------------------------------------------------------
    // mode 0, reply bit read just before the rising spick
    task spi_byte(input logic [7:0] tx, output logic [7:0] rx);
        int i;
        begin
            for (i = 7; i >= 0; i--)
            begin
                spido <= tx[i];
                repeat (3) @(posedge fclk);
                @(negedge fclk);
                rx[i] = spidi;
                @(posedge fclk);
                spick <= 1'b1;
                repeat (4) @(posedge fclk);
                spick <= 1'b0;
            end
        end
    endtask

    task spi_transfer(input logic [7:0] cmd, input logic [7:0] data, output logic [7:0] reply);
        logic [7:0] junk;
        begin
            spi_byte(cmd, junk);
            repeat (4) @(posedge fclk);
            spics_n <= 1'b0;
            repeat (8) @(posedge fclk);
            spi_byte(data, reply);
            repeat (4) @(posedge fclk);
            spics_n <= 1'b1;
            repeat (8) @(posedge fclk);
        end
    endtask

    // one command with reply check and model update
    task send(input logic [7:0] cmd, input logic [7:0] data);
        logic [7:0] exp_reply;
        logic [7:0] reply;
        begin
            exp_reply = 8'hff;
            if (cmd == board_pkg::CMD_FLASH_DATA)
            begin
                // with oe low the bus carries the last write byte
                if (m_oe)
                    exp_reply = exp_mem[m_addr[8:0]];
                else
                    exp_reply = m_wdata;
            end
            else if (cmd == board_pkg::CMD_COVOX)
                exp_reply = ~m_covox;

            spi_transfer(cmd, data, reply);
            check("spidi reply", reply, exp_reply);

            case (cmd)
                board_pkg::CMD_FLASH_LOADDR:
                    m_addr[7:0] = data;
                board_pkg::CMD_FLASH_MIDADDR:
                    m_addr[15:8] = data;
                board_pkg::CMD_FLASH_HIADDR:
                    m_addr[18:16] = data[2:0];
                board_pkg::CMD_FLASH_DATA:
                begin
                    m_wdata = data;
                    if (m_postinc)
                        m_addr[13:0] = m_addr[13:0] + 14'd1;
                end
                board_pkg::CMD_FLASH_CTRL:
                begin
                    // falling we with the bus driven stores the write byte
                    if (m_we && !data[2] && !data[1])
                        exp_mem[m_addr[8:0]] = m_wdata;
                    {m_postinc, m_we, m_oe, m_cs} = data[3:0];
                end
                board_pkg::CMD_COVOX:
                    m_covox = data;
                board_pkg::CMD_INT_CONTROL:
                    m_int_en = data[0];
                default:
                begin
                    // sd and unknown commands leave the model alone
                end
            endcase
            check_pins();
        end
    endtask

    task set_addr(input logic [18:0] addr);
        logic [31:0] rnd;
        begin
            rnd = $urandom;
            send(board_pkg::CMD_FLASH_LOADDR, addr[7:0]);
            send(board_pkg::CMD_FLASH_MIDADDR, addr[15:8]);
            send(board_pkg::CMD_FLASH_HIADDR, {rnd[4:0], addr[18:16]});
        end
    endtask

    task wait_clkz(input logic level, output int cycles);
        begin
            cycles = 0;
            @(negedge fclk);
            cycles = 1;
            while (clkz_out !== level && cycles < TIMEOUT)
            begin
                @(negedge fclk);
                cycles = cycles + 1;
            end
            if (clkz_out !== level)
                fail_run("timeout while waiting for clkz_out to toggle");
        end
    endtask

    // sd lines while the data phase of cmd is open
    task sd_phase(input logic [7:0] cmd, input logic card_sel, input logic passes);
        logic [7:0]  junk;
        logic [31:0] rnd;
        int          i;
        begin
            spi_byte(cmd, junk);
            repeat (4) @(posedge fclk);
            spics_n <= 1'b0;
            repeat (8) @(posedge fclk);
            for (i = 0; i < 32; i++)
            begin
                rnd = $urandom;
                spick <= rnd[0];
                spido <= rnd[1];
                sddi  <= rnd[2];
                @(negedge fclk);
                check("sdcs_n", sdcs_n, !card_sel);
                if (passes)
                begin
                    check("sdclk", sdclk, spick);
                    check("sddo", sddo, spido);
                    check("spidi", spidi, sddi);
                end
                else
                begin
                    check("sdclk", sdclk, 1'b0);
                    check("sddo", sddo, 1'b1);
                end
                @(posedge fclk);
            end
            spick <= 1'b0;
            spido <= 1'b1;
            sddi  <= 1'b1;
            repeat (4) @(posedge fclk);
            spics_n <= 1'b1;
            repeat (8) @(posedge fclk);
        end
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial
    begin : main
        logic [31:0] rnd;
        logic [7:0]  v;
        int          k;
        int          n;
        int          cnt;
        int          c0;
        int          c1;

        void'($urandom(32'h63a5_150e));
        rst_n   <= 1'b0;
        spick   <= 1'b0;
        spics_n <= 1'b1;
        spido   <= 1'b1;
        sddi    <= 1'b1;
        for (k = 0; k < 512; k++)
        begin
            flash_mem[k] = fill_byte(k);
            exp_mem[k] = fill_byte(k);
        end
        m_addr = '0;
        {m_cs, m_oe, m_we, m_postinc} = 4'b0000;
        m_wdata = 8'h00;
        m_covox = 8'h7f;
        m_int_en = 1'b0;

        repeat (2) @(posedge fclk);
        rst_n <= 1'b1;
        repeat (2) @(posedge fclk);
        check("spiint_n", spiint_n, 1'b1);
        check_pins();

        // address pins
        for (n = 0; n < 16; n++)
        begin
            rnd = $urandom;
            if (rnd[9:8] == 2'd0)
                send(board_pkg::CMD_FLASH_LOADDR, rnd[7:0]);
            else if (rnd[9:8] == 2'd1)
                send(board_pkg::CMD_FLASH_MIDADDR, rnd[7:0]);
            else
                send(board_pkg::CMD_FLASH_HIADDR, rnd[7:0]);
        end

        // reads at random addresses
        send(board_pkg::CMD_FLASH_CTRL, 8'h03);
        for (n = 0; n < 8; n++)
        begin
            rnd = $urandom;
            set_addr(rnd[18:0]);
            send(board_pkg::CMD_FLASH_DATA, rnd[31:24]);
        end

        // post-increment across the 14-bit wrap
        rnd = $urandom;
        set_addr({rnd[4:0], 14'h3ffd});
        send(board_pkg::CMD_FLASH_CTRL, 8'h0b);
        for (n = 0; n < 6; n++)
        begin
            rnd = $urandom;
            send(board_pkg::CMD_FLASH_DATA, rnd[7:0]);
        end

        // write with a we pulse, then read back
        for (n = 0; n < 6; n++)
        begin
            rnd = $urandom;
            send(board_pkg::CMD_FLASH_CTRL, 8'h01);
            set_addr(rnd[18:0]);
            send(board_pkg::CMD_FLASH_DATA, rnd[31:24]);
            send(board_pkg::CMD_FLASH_CTRL, 8'h05);
            send(board_pkg::CMD_FLASH_CTRL, 8'h01);
            send(board_pkg::CMD_FLASH_CTRL, 8'h03);
            send(board_pkg::CMD_FLASH_DATA, rnd[23:16]);
        end

        // covox echo and pwm duty
        for (n = 0; n < 5; n++)
        begin
            rnd = $urandom;
            v = (n == 0) ? 8'h00 : (n == 1) ? 8'hff : rnd[7:0];
            send(board_pkg::CMD_COVOX, v);
            send(board_pkg::CMD_COVOX, v);
            repeat (512) @(posedge fclk);
            cnt = 0;
            repeat (256)
            begin
                @(negedge fclk);
                if (beep)
                    cnt = cnt + 1;
            end
            check("beep high cycles", cnt, v);
            @(posedge fclk);
        end

        // covox interrupt and z80 clock
        rnd = $urandom;
        send(board_pkg::CMD_INT_CONTROL, {rnd[7:1], 1'b1});
        cnt = 0;
        repeat (1024)
        begin
            @(negedge fclk);
            if (!spiint_n)
                cnt = cnt + 1;
        end
        check("spiint_n low cycles", cnt, 4);
        wait_clkz(1'b0, c0);
        wait_clkz(1'b1, c0);
        wait_clkz(1'b0, c0);
        wait_clkz(1'b1, c1);
        check("clkz_out period", c0 + c1, 8);
        @(posedge fclk);
        send(board_pkg::CMD_INT_CONTROL, {rnd[15:9], 1'b0});
        cnt = 0;
        repeat (1024)
        begin
            @(negedge fclk);
            if (!spiint_n)
                cnt = cnt + 1;
        end
        check("spiint_n low cycles", cnt, 0);
        @(posedge fclk);

        // sd card pass-through
        sd_phase(board_pkg::CMD_SD_CS0, 1'b1, 1'b1);
        sd_phase(board_pkg::CMD_SD_CS1, 1'b0, 1'b1);
        sd_phase(8'h3c, 1'b0, 1'b0);

        if (uut.u_checks.fail_count == 0)
        begin
            $display("All tests passed!");
            $finish;
        end
        else
            fail_run("concurrent assertions failed during the run");
    end

endmodule

`default_nettype wire

// File: test/board_test_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module board_test_assertions (
    input wire logic fclk,
    input wire logic rst_n,
    input wire logic spick,
    input wire logic spics_n,
    input wire logic sdclk,
    input wire logic sddo,
    input wire logic sdcs_n,
    input wire logic spiint_n
);

    // cycles spent low so far in the current spiint_n pulse
    logic [2:0] low_cnt;

    // number of assertion failures so far
    int fail_count = 0;

    always_ff @(posedge fclk)
    begin
        if (!rst_n || spiint_n)
            low_cnt <= 3'd0;
        else if (low_cnt != 3'd7)
            low_cnt <= low_cnt + 3'd1;
    end

    // sd lines idle while the avr is deselected
    idle_sd: assert property (@(posedge fclk) disable iff (!rst_n)
        spics_n |-> (!sdclk && sddo))
        else
        begin
            fail_count = fail_count + 1;
            $error("sd clock or data active while spics_n is high");
        end

    card_clock: assert property (@(posedge fclk) disable iff (!rst_n)
        !sdcs_n |-> (sdclk == spick))
        else
        begin
            fail_count = fail_count + 1;
            $error("sdclk does not follow spick while the card is selected");
        end

    int_width: assert property (@(posedge fclk) disable iff (!rst_n)
        !spiint_n |-> (low_cnt < 3'd4))
        else
        begin
            fail_count = fail_count + 1;
            $error("spiint_n low for more than 4 cycles");
        end

endmodule

bind board_test_top board_test_assertions u_checks (
    .fclk     (fclk),
    .rst_n    (rst_n),
    .spick    (spick),
    .spics_n  (spics_n),
    .sdclk    (sdclk),
    .sddo     (sddo),
    .sdcs_n   (sdcs_n),
    .spiint_n (spiint_n)
);

`default_nettype wire

// File: hdl/board_test_top.sv
`timescale 1ns/1ps
`default_nettype none

module board_test_top #(
    parameter int OSC_W = 10
) (
    input  logic        fclk,
    input  logic        rst_n,
    input  logic        spick,
    input  logic        spics_n,
    input  logic        spido,
    input  logic        sddi,
    output logic        spidi,
    output logic        sdcs_n,
    output logic        sddo,
    output logic        sdclk,
    output logic        beep,
    output logic        clkz_out,
    output logic        spiint_n,
    output logic [13:0] a,
    output logic        rompg0_n,
    output logic        dos_n,
    output logic        rompg2,
    output logic        rompg3,
    output logic        rompg4,
    output logic        csrom,
    output logic        romoe_n,
    output logic        romwe_n,
    inout  wire  [7:0]  d
);

    localparam int PG = board_pkg::FLASH_PAGE_LSB;

    logic [board_pkg::FLASH_ADDR_W-1:0] flash_addr;
    logic                               flash_cs;
    logic                               flash_oe;
    logic                               flash_we;
    logic [7:0]                         flash_wdata;
    logic [7:0]                         covox_value;
    logic                               covox_int_en;

    spi_xfer_if xfer ();

    avr_spi_slave u_spi (
        .fclk    (fclk),
        .rst_n   (rst_n),
        .spick   (spick),
        .spics_n (spics_n),
        .spido   (spido),
        .sddi    (sddi),
        .spidi   (spidi),
        .sddo    (sddo),
        .sdclk   (sdclk),
        .sdcs_n  (sdcs_n),
        .xfer    (xfer.slave)
    );

    avr_cmd_regs u_regs (
        .fclk         (fclk),
        .rst_n        (rst_n),
        .flash_rdata  (d),
        .flash_addr   (flash_addr),
        .flash_cs     (flash_cs),
        .flash_oe     (flash_oe),
        .flash_we     (flash_we),
        .flash_wdata  (flash_wdata),
        .covox_value  (covox_value),
        .covox_int_en (covox_int_en),
        .xfer         (xfer.regs)
    );

    covox_pwm #(
        .OSC_W (OSC_W)
    ) u_covox (
        .fclk         (fclk),
        .rst_n        (rst_n),
        .covox_value  (covox_value),
        .covox_int_en (covox_int_en),
        .beep         (beep),
        .clkz_out     (clkz_out),
        .spiint_n     (spiint_n)
    );

    // ------------------------------------------------------------
    // flash pins
    // ------------------------------------------------------------
    assign a        = flash_addr[PG-1:0];
    assign rompg0_n = ~flash_addr[PG];
    // dos_n doubles as page bit 1
    assign {rompg4, rompg3, rompg2, dos_n} = flash_addr[PG+4:PG+1];

    assign csrom   = flash_cs;
    assign romoe_n = ~flash_oe;
    assign romwe_n = ~flash_we;

    // flash owns the bus while reading
    assign d = flash_oe ? 8'bzzzz_zzzz : flash_wdata;

endmodule

`default_nettype wire

// File: hdl/covox_pwm.sv
`timescale 1ns/1ps
`default_nettype none

module covox_pwm #(
    parameter int OSC_W = 10
) (
    input  logic       fclk,
    input  logic       rst_n,
    input  logic [7:0] covox_value,
    input  logic       covox_int_en,
    output logic       beep,
    output logic       clkz_out,
    output logic       spiint_n
);

    logic [OSC_W-1:0] osc;
    // sample of covox_value held for one 256-count pwm period
    logic [7:0]       covox_work;

    // ------------------------------------------------------------
    // free-running oscillator and pwm
    // ------------------------------------------------------------
    always_ff @(posedge fclk)
    begin
        if (!rst_n)
        begin
            osc        <= '0;
            covox_work <= 8'd0;
            beep       <= 1'b0;
        end
        else
        begin
            osc  <= osc + 1'b1;
            beep <= (osc[7:0] < covox_work);
            if (osc[7:0] == 8'd0)
                covox_work <= covox_value;
        end
    end

    // z80 clock, fclk divided by 8
    assign clkz_out = osc[2];

    // low for the first 4 counts of each oscillator period
    always_ff @(posedge fclk)
    begin
        if (!rst_n)
            spiint_n <= 1'b1;
        else
            spiint_n <= !(covox_int_en && (osc[OSC_W-1:2] == '0));
    end

endmodule

`default_nettype wire

// File: hdl/avr_cmd_regs.sv
`timescale 1ns/1ps
`default_nettype none

module avr_cmd_regs (
    input  logic                               fclk,
    input  logic                               rst_n,
    input  logic [7:0]                         flash_rdata,
    output logic [board_pkg::FLASH_ADDR_W-1:0] flash_addr,
    output logic                               flash_cs,
    output logic                               flash_oe,
    output logic                               flash_we,
    output logic [7:0]                         flash_wdata,
    output logic [7:0]                         covox_value,
    output logic                               covox_int_en,
    spi_xfer_if.regs                           xfer
);

    localparam int INC_W = board_pkg::FLASH_INC_W;
    localparam int HI_W  = board_pkg::FLASH_ADDR_W - 16;

    localparam logic [INC_W-1:0] INC_ONE = 1;

    logic flash_postinc;

    // ------------------------------------------------------------
    // register writes at the end of a transfer
    // ------------------------------------------------------------
    always_ff @(posedge fclk)
    begin
        if (!rst_n)
        begin
            flash_addr    <= '0;
            flash_cs      <= 1'b0;
            flash_oe      <= 1'b0;
            flash_we      <= 1'b0;
            flash_postinc <= 1'b0;
            covox_value   <= board_pkg::COVOX_RESET;
            covox_int_en  <= 1'b0;
        end
        else if (xfer.xfer_end)
        begin
            case (xfer.cmd)
                board_pkg::CMD_FLASH_LOADDR:
                    flash_addr[7:0] <= xfer.wdata.raw;
                board_pkg::CMD_FLASH_MIDADDR:
                    flash_addr[15:8] <= xfer.wdata.raw;
                board_pkg::CMD_FLASH_HIADDR:
                    flash_addr[board_pkg::FLASH_ADDR_W-1:16] <= xfer.wdata.raw[HI_W-1:0];
                board_pkg::CMD_FLASH_DATA:
                begin
                    // wraps inside the page, upper bits untouched
                    if (flash_postinc)
                        flash_addr[INC_W-1:0] <= flash_addr[INC_W-1:0] + INC_ONE;
                end
                board_pkg::CMD_FLASH_CTRL:
                begin
                    flash_cs      <= xfer.wdata.flash_ctrl.cs;
                    flash_oe      <= xfer.wdata.flash_ctrl.oe;
                    flash_we      <= xfer.wdata.flash_ctrl.we;
                    flash_postinc <= xfer.wdata.flash_ctrl.postinc;
                end
                board_pkg::CMD_COVOX:
                    covox_value <= xfer.wdata.raw;
                board_pkg::CMD_INT_CONTROL:
                    covox_int_en <= xfer.wdata.int_ctrl.enable_covox;
                default:
                begin
                    // sd commands and unknown numbers change nothing here
                end
            endcase
        end
    end

    // write byte for the flash data bus
    always_ff @(posedge fclk)
    begin
        if (xfer.xfer_end && (xfer.cmd == board_pkg::CMD_FLASH_DATA))
            flash_wdata <= xfer.wdata.raw;
    end

    // ------------------------------------------------------------
    // reply byte, chosen as the data phase opens
    // ------------------------------------------------------------
    always_ff @(posedge fclk)
    begin
        if (!rst_n)
            xfer.reply <= board_pkg::REPLY_IDLE;
        else if (xfer.xfer_start)
        begin
            case (xfer.cmd)
                board_pkg::CMD_FLASH_DATA:
                    xfer.reply <= flash_rdata;
                // inverted so the avr can tell a live link from a stuck line
                board_pkg::CMD_COVOX:
                    xfer.reply <= ~covox_value;
                default:
                    xfer.reply <= board_pkg::REPLY_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/avr_spi_slave.sv
`timescale 1ns/1ps
`default_nettype none

module avr_spi_slave (
    input  logic        fclk,
    input  logic        rst_n,
    input  logic        spick,
    input  logic        spics_n,
    input  logic        spido,
    input  logic        sddi,
    output logic        spidi,
    output logic        sddo,
    output logic        sdclk,
    output logic        sdcs_n,
    spi_xfer_if.slave   xfer
);

    // bit order {spics_n, spick, spido}
    logic [2:0] sync1;
    logic [2:0] sync2;
    logic       cs_d;
    logic       ck_d;
    logic [2:0] bitptr;

    logic cs_s;
    logic ck_s;
    logic do_s;
    logic ck_rise;
    logic ck_fall;
    logic sd_cmd;
    logic sd_selected;

    assign cs_s = sync2[2];
    assign ck_s = sync2[1];
    assign do_s = sync2[0];

    assign ck_rise = ck_s & ~ck_d;
    assign ck_fall = ~ck_s & ck_d;

    // ------------------------------------------------------------
    // synchroniser and edge detect
    // ------------------------------------------------------------
    always_ff @(posedge fclk)
    begin
        if (!rst_n)
        begin
            sync1 <= 3'b101;
            sync2 <= 3'b101;
            cs_d  <= 1'b1;
            ck_d  <= 1'b0;
        end
        else
        begin
            sync1 <= {spics_n, spick, spido};
            sync2 <= sync1;
            cs_d  <= cs_s;
            ck_d  <= ck_s;
        end
    end

    // strobes registered once more so the bank sees them 4 cycles after the pin
    always_ff @(posedge fclk)
    begin
        if (!rst_n)
        begin
            xfer.xfer_end   <= 1'b0;
            xfer.xfer_start <= 1'b0;
        end
        else
        begin
            xfer.xfer_end   <= cs_s & ~cs_d;
            xfer.xfer_start <= ~cs_s & cs_d;
        end
    end

    // command byte while deselected, data byte while selected
    always_ff @(posedge fclk)
    begin
        if (!rst_n)
            xfer.cmd <= 8'hff;
        else if (ck_rise)
        begin
            if (cs_s)
                xfer.cmd <= {xfer.cmd[6:0], do_s};
            else
                xfer.wdata.raw <= {xfer.wdata.raw[6:0], do_s};
        end
    end

    // reply bit pointer, msb first
    always_ff @(posedge fclk)
    begin
        if (!rst_n || cs_s)
            bitptr <= 3'd7;
        else if (ck_fall)
            bitptr <= bitptr - 3'd1;
    end

    // ------------------------------------------------------------
    // sd card pass-through on the raw pins
    // ------------------------------------------------------------
    assign sd_cmd = (xfer.cmd == board_pkg::CMD_SD_CS0) ||
                    (xfer.cmd == board_pkg::CMD_SD_CS1);
    assign sd_selected = sd_cmd && !spics_n;

    assign spidi  = sd_selected ? sddi  : xfer.reply[bitptr];
    assign sddo   = sd_selected ? spido : 1'b1;
    assign sdclk  = sd_selected ? spick : 1'b0;
    // only a1 actually selects the card
    assign sdcs_n = !((xfer.cmd == board_pkg::CMD_SD_CS0) && !spics_n);

endmodule

`default_nettype wire

// File: hdl/spi_xfer_if.sv
`timescale 1ns/1ps
`default_nettype none

// one finished avr spi transfer, slave side to register bank
interface spi_xfer_if;

    logic [7:0]            cmd;
    board_pkg::cmd_data_t  wdata;
    logic                  xfer_end;
    logic                  xfer_start;
    // byte shifted back to the avr during the data phase
    logic [7:0]            reply;

    modport slave (
        output cmd, wdata, xfer_end, xfer_start,
        input  reply
    );

    modport regs (
        input  cmd, wdata, xfer_end, xfer_start,
        output reply
    );

endinterface

`default_nettype wire

// File: hdl/board_pkg.sv
`default_nettype none

package board_pkg;

    // ------------------------------------------------------------
    // command numbers sent with spics_n high
    // ------------------------------------------------------------
    localparam logic [7:0] CMD_SD_CS0        = 8'ha1;
    localparam logic [7:0] CMD_SD_CS1        = 8'ha2;
    localparam logic [7:0] CMD_FLASH_LOADDR  = 8'ha3;
    localparam logic [7:0] CMD_FLASH_MIDADDR = 8'ha4;
    localparam logic [7:0] CMD_FLASH_HIADDR  = 8'ha5;
    localparam logic [7:0] CMD_FLASH_DATA    = 8'ha6;
    localparam logic [7:0] CMD_FLASH_CTRL    = 8'ha7;
    localparam logic [7:0] CMD_COVOX         = 8'h53;
    localparam logic [7:0] CMD_INT_CONTROL   = 8'h54;

    // ------------------------------------------------------------
    // widths and reset values
    // ------------------------------------------------------------
    localparam int FLASH_ADDR_W   = 19;
    // first address bit routed to the rom page pins
    localparam int FLASH_PAGE_LSB = 14;
    // post-increment wraps inside one 16k page
    localparam int FLASH_INC_W    = 14;

    localparam logic [7:0] COVOX_RESET = 8'h7f;
    localparam logic [7:0] REPLY_IDLE  = 8'hff;

    // data byte of a transfer, meaning depends on the command
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [3:0] rsvd;
            logic       postinc;
            logic       we;
            logic       oe;
            logic       cs;
        } flash_ctrl;
        struct packed {
            logic [6:0] rsvd;
            logic       enable_covox;
        } int_ctrl;
    } cmd_data_t;

endpackage

`default_nettype wire
